// File: common/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// Datapath word
`define WORD_WIDTH 16

// PADDSB lane geometry
`define LANE_WIDTH 4
`define NUM_LANES 4

// Returned for opcodes 1100 to 1111
`define UNDEF_RESULT 16'hFFFF

`endif

// File: common/alu_pkg.sv
`include "alu_consts.svh"

package alu_pkg;

    // Opcodes 1100 to 1111 are left undefined on purpose
    typedef enum logic [3:0] {
        OP_ADD    = 4'b0000, // Saturating add
        OP_SUB    = 4'b0001, // Saturating subtract
        OP_XOR    = 4'b0010,
        OP_RED    = 4'b0011, // Byte reduction
        OP_SLL    = 4'b0100,
        OP_SRA    = 4'b0101,
        OP_ROR    = 4'b0110,
        OP_PADDSB = 4'b0111, // Four nibble lanes
        OP_LW     = 4'b1000, // Address add
        OP_SW     = 4'b1001, // Address add
        OP_LLB    = 4'b1010,
        OP_LHB    = 4'b1011
    } opcodeE;

    // Incoming request
    typedef struct packed {
        opcodeE                  opcode;
        logic [`WORD_WIDTH-1:0] in1;
        logic [`WORD_WIDTH-1:0] in2;
    } aluReqT;

    // Flag values, also used as per-bit enables
    typedef struct packed {
        logic zero;
        logic overflow;
        logic neg;
    } flagsT;

    // Outgoing response
    typedef struct packed {
        logic [`WORD_WIDTH-1:0] result;
        flagsT                   flags;
    } aluRespT;

endpackage

// File: hw/aluInputStage.sv
`timescale 1ns/1ns

module aluInputStage (
    input  logic            clk,
    input  logic            rst,
    input  logic            en,
    input  alu_pkg::aluReqT req,
    output alu_pkg::aluReqT stReq,
    output logic            stValid
);

    // Payload captured every cycle, qualified by stValid
    always_ff @(posedge clk) begin
        stReq <= req;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stValid <= 1'b0;
        end else begin
            stValid <= en;
        end
    end

endmodule

// File: hw/addSub.sv
`timescale 1ns/1ns

`include "alu_consts.svh"

module addSub (
    input  logic [`WORD_WIDTH-1:0] a,
    input  logic [`WORD_WIDTH-1:0] b,
    input  logic                   sub,
    output logic [`WORD_WIDTH-1:0] sum,
    output logic                   ovf
);

    localparam int W = `WORD_WIDTH;

    logic [W-1:0] bEff;
    logic [W-1:0] raw;
    logic         posOvf;
    logic         negOvf;

    assign bEff = sub ? ~b : b; // Two's complement with carry in below
    assign raw  = a + bEff + {{(W-1){1'b0}}, sub};

    // Same operand signs, different result sign
    assign posOvf = ~a[W-1] & ~bEff[W-1] & raw[W-1];
    assign negOvf = a[W-1] & bEff[W-1] & ~raw[W-1];

    always_comb begin
        if (posOvf) begin
            sum = {1'b0, {(W-1){1'b1}}}; // 7FFF
        end else if (negOvf) begin
            sum = {1'b1, {(W-1){1'b0}}}; // 8000
        end else begin
            sum = raw;
        end
    end

    assign ovf = posOvf | negOvf;

endmodule

// File: hw/shifter.sv
`timescale 1ns/1ns

`include "alu_consts.svh"

module shifter (
    input  logic [`WORD_WIDTH-1:0] din,
    input  logic [3:0]             amount,
    input  alu_pkg::opcodeE        opcode,
    output logic [`WORD_WIDTH-1:0] dout
);

    localparam int W          = `WORD_WIDTH;
    localparam int NUM_LEVELS = 4;

    logic [W-1:0] stage [0:NUM_LEVELS];
    logic         isShift;

    assign stage[0] = din;

    // Level i moves by 2**i when amount[i] is set
    for (genvar i = 0; i < NUM_LEVELS; i++) begin : gLevel
        localparam int K = 1 << i;

        logic [W-1:0] shifted;

        always_comb begin
            case (opcode)
                alu_pkg::OP_SLL: shifted = {stage[i][W-1-K:0], {K{1'b0}}};
                alu_pkg::OP_SRA: shifted = {{K{stage[i][W-1]}}, stage[i][W-1:K]};
                alu_pkg::OP_ROR: shifted = {stage[i][K-1:0], stage[i][W-1:K]};
                default:         shifted = stage[i];
            endcase
        end

        assign stage[i+1] = amount[i] ? shifted : stage[i];
    end

    assign isShift = opcode inside {alu_pkg::OP_SLL, alu_pkg::OP_SRA, alu_pkg::OP_ROR};

    assign dout = isShift ? stage[NUM_LEVELS] : '0; // Unused for other opcodes

endmodule

// File: hw/reduction.sv
`timescale 1ns/1ns

`include "alu_consts.svh"

module reduction (
    input  logic [`WORD_WIDTH-1:0] a,
    input  logic [`WORD_WIDTH-1:0] b,
    output logic [`WORD_WIDTH-1:0] dout
);

    localparam int W = `WORD_WIDTH;

    logic [8:0] sumA;
    logic [8:0] sumB;
    logic [9:0] total;

    // First level, byte pairs sign-extended to 9 bits
    assign sumA = {a[15], a[15:8]} + {a[7], a[7:0]};
    assign sumB = {b[15], b[15:8]} + {b[7], b[7:0]};

    assign total = {sumA[8], sumA} + {sumB[8], sumB}; // Second level

    assign dout = {{(W-10){total[9]}}, total};

endmodule

// File: paddsb/satNibbleAdder.sv
`timescale 1ns/1ns

`include "alu_consts.svh"

module satNibbleAdder (
    input  logic [`LANE_WIDTH-1:0] a,
    input  logic [`LANE_WIDTH-1:0] b,
    output logic [`LANE_WIDTH-1:0] sum
);

    localparam int L = `LANE_WIDTH;

    logic [L-1:0] raw;
    logic         posSat;
    logic         negSat;

    assign raw    = a + b;
    assign posSat = ~a[L-1] & ~b[L-1] & raw[L-1];
    assign negSat = a[L-1] & b[L-1] & ~raw[L-1];

    always_comb begin
        if (posSat) begin
            sum = {1'b0, {(L-1){1'b1}}}; // Clamp to +7
        end else if (negSat) begin
            sum = {1'b1, {(L-1){1'b0}}}; // Clamp to -8
        end else begin
            sum = raw;
        end
    end

endmodule

// File: hw/aluControl.sv
`timescale 1ns/1ns

`include "alu_consts.svh"

module aluControl (
    input  alu_pkg::opcodeE        opcode,
    input  logic [`WORD_WIDTH-1:0] in1,
    input  logic [`WORD_WIDTH-1:0] in2,
    input  logic [`WORD_WIDTH-1:0] adderOut,
    input  logic [`WORD_WIDTH-1:0] xorOut,
    input  logic [`WORD_WIDTH-1:0] shiftOut,
    input  logic [`WORD_WIDTH-1:0] redOut,
    input  logic [`WORD_WIDTH-1:0] paddsbOut,
    output logic [`WORD_WIDTH-1:0] selResult,
    output logic                   sub,
    output alu_pkg::flagsT         flagEn
);

    localparam int W = `WORD_WIDTH;
    localparam int H = W / 2;

    always_comb begin
        selResult = `UNDEF_RESULT; // Also covers 1100 to 1111
        sub       = 1'b0;
        flagEn    = '0;

        case (opcode)
            alu_pkg::OP_ADD: begin
                selResult = adderOut;
                flagEn    = '1;
            end
            alu_pkg::OP_SUB: begin
                selResult = adderOut;
                sub       = 1'b1;
                flagEn    = '1;
            end
            alu_pkg::OP_XOR: begin
                selResult   = xorOut;
                flagEn.zero = 1'b1;
            end
            alu_pkg::OP_RED: begin
                selResult = redOut;
            end
            alu_pkg::OP_SLL, alu_pkg::OP_SRA, alu_pkg::OP_ROR: begin
                selResult   = shiftOut;
                flagEn.zero = 1'b1;
            end
            alu_pkg::OP_PADDSB: begin
                selResult = paddsbOut;
            end
            alu_pkg::OP_LW, alu_pkg::OP_SW: begin
                selResult = adderOut; // Base plus offset
            end
            alu_pkg::OP_LLB: begin
                selResult = {in1[W-1:H], in2[H-1:0]};
            end
            alu_pkg::OP_LHB: begin
                selResult = {in2[H-1:0], in1[H-1:0]};
            end
            default: begin
            end
        endcase
    end

endmodule

// File: hw/flagRegister.sv
`timescale 1ns/1ns

`include "alu_consts.svh"

module flagRegister (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stValid,
    input  logic [`WORD_WIDTH-1:0] selResult,
    input  alu_pkg::flagsT         flagEn,
    input  logic                   ovf,
    output logic                   outValid,
    output alu_pkg::aluRespT       resp
);

    localparam int W = `WORD_WIDTH;

    alu_pkg::flagsT newFlags;
    alu_pkg::flagsT nextFlags;

    assign newFlags.zero     = (selResult == '0);
    assign newFlags.overflow = ovf;
    assign newFlags.neg      = selResult[W-1];

    // Only enabled bits move, the rest hold
    always_comb begin
        nextFlags.zero     = flagEn.zero     ? newFlags.zero     : resp.flags.zero;
        nextFlags.overflow = flagEn.overflow ? newFlags.overflow : resp.flags.overflow;
        nextFlags.neg      = flagEn.neg      ? newFlags.neg      : resp.flags.neg;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
            resp     <= '0;
        end else begin
            outValid <= stValid;
            if (stValid) begin
                resp.result <= selResult;
                resp.flags  <= nextFlags;
            end
        end
    end

endmodule

// File: hw/aluTop.sv
`timescale 1ns/1ns

`include "alu_consts.svh"

module aluTop (
    input  logic              clk,
    input  logic              rst,
    input  logic              en,
    input  alu_pkg::aluReqT   req,
    output logic              outValid,
    output alu_pkg::aluRespT  resp
);

    localparam int L = `LANE_WIDTH;

    alu_pkg::aluReqT        stReq;
    logic                   stValid;
    logic [`WORD_WIDTH-1:0] adderOut;
    logic [`WORD_WIDTH-1:0] xorOut;
    logic [`WORD_WIDTH-1:0] shiftOut;
    logic [`WORD_WIDTH-1:0] redOut;
    logic [`WORD_WIDTH-1:0] paddsbOut;
    logic [`WORD_WIDTH-1:0] selResult;
    logic                   sub;
    logic                   ovf;
    alu_pkg::flagsT         flagEn;

    aluInputStage uInputStage (
        .clk     (clk),
        .rst     (rst),
        .en      (en),
        .req     (req),
        .stReq   (stReq),
        .stValid (stValid)
    );

    addSub uAddSub (
        .a   (stReq.in1),
        .b   (stReq.in2),
        .sub (sub),
        .sum (adderOut),
        .ovf (ovf)
    );

    assign xorOut = stReq.in1 ^ stReq.in2;

    shifter uShifter (
        .din    (stReq.in1),
        .amount (stReq.in2[3:0]), // Low nibble is the shift count
        .opcode (stReq.opcode),
        .dout   (shiftOut)
    );

    reduction uReduction (
        .a    (stReq.in1),
        .b    (stReq.in2),
        .dout (redOut)
    );

    for (genvar i = 0; i < `NUM_LANES; i++) begin : gLane
        satNibbleAdder uLane (
            .a   (stReq.in1[i*L +: L]),
            .b   (stReq.in2[i*L +: L]),
            .sum (paddsbOut[i*L +: L])
        );
    end

    aluControl uControl (
        .opcode    (stReq.opcode),
        .in1       (stReq.in1),
        .in2       (stReq.in2),
        .adderOut  (adderOut),
        .xorOut    (xorOut),
        .shiftOut  (shiftOut),
        .redOut    (redOut),
        .paddsbOut (paddsbOut),
        .selResult (selResult),
        .sub       (sub),
        .flagEn    (flagEn)
    );

    flagRegister uFlagRegister (
        .clk       (clk),
        .rst       (rst),
        .stValid   (stValid),
        .selResult (selResult),
        .flagEn    (flagEn),
        .ovf       (ovf),
        .outValid  (outValid),
        .resp      (resp)
    );

endmodule

// File: dv/alu_props.sv
`timescale 1ns/1ns

module aluProps (
    input logic             clk,
    input logic             rst,
    input logic             en,
    input logic             outValid,
    input alu_pkg::aluRespT resp
);

    property pResetQuiet;
        @(posedge clk) rst |=> !outValid ##1 !outValid; // Both pipeline stages cleared
    endproperty

    property pLatency;
        @(posedge clk) disable iff (rst) en |-> ##2 outValid;
    endproperty

    property pNoSpurious;
        @(posedge clk) disable iff (rst) outValid |-> $past(en, 2);
    endproperty

    property pFlagsOnValid;
        @(posedge clk) disable iff (rst) !$stable(resp.flags) |-> outValid;
    endproperty

    aResetQuiet: assert property (pResetQuiet)
        else $error("outValid high during reset or in the cycle after it");
    aLatency: assert property (pLatency)
        else $error("request not answered two cycles after en");
    aNoSpurious: assert property (pNoSpurious)
        else $error("outValid without a request two cycles earlier");
    aFlagsOnValid: assert property (pFlagsOnValid)
        else $error("flag register changed without outValid");

endmodule

bind aluTop aluProps uProps (
    .clk      (clk),
    .rst      (rst),
    .en       (en),
    .outValid (outValid),
    .resp     (resp)
);

// File: dv/alu_tb.sv
`timescale 1ns/1ns

`include "alu_consts.svh"

module alu_tb;

    localparam int W       = `WORD_WIDTH;
    localparam int L       = `LANE_WIDTH;
    localparam int TIMEOUT = 20;

    logic             clk;
    logic             rst;
    logic             en;
    alu_pkg::aluReqT  req;
    logic             outValid;
    alu_pkg::aluRespT resp;
    alu_pkg::flagsT   modelFlags; // Reference copy of the flag register

    aluTop u_dut (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .req      (req),
        .outValid (outValid),
        .resp     (resp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compareResult(input logic [W-1:0] got, input logic [W-1:0] exp,
                                 input string what);
        if (got !== exp) begin
            abortRun($sformatf("error at %0t ns: %s result %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic compareFlags(input alu_pkg::flagsT got, input alu_pkg::flagsT exp,
                                input string what);
        if (got !== exp) begin
            abortRun($sformatf("error at %0t ns: %s flags z%b v%b n%b, expected z%b v%b n%b",
                               $time, what, got.zero, got.overflow, got.neg,
                               exp.zero, exp.overflow, exp.neg));
        end
    endtask

    task automatic compareResp(input alu_pkg::aluRespT got, input alu_pkg::aluRespT exp,
                               input string what);
        compareResult(got.result, exp.result, what);
        compareFlags(got.flags, exp.flags, what);
    endtask

    function automatic int clampInt(input int value, input int lo, input int hi);
        if (value > hi) begin
            return hi;
        end
        if (value < lo) begin
            return lo;
        end
        return value;
    endfunction

    function automatic logic [W-1:0] randWord();
        return W'($urandom);
    endfunction

    function automatic alu_pkg::aluReqT makeReq(input logic [3:0] code,
                                                input logic [W-1:0] in1,
                                                input logic [W-1:0] in2);
        alu_pkg::aluReqT r;
        r.opcode = alu_pkg::opcodeE'(code);
        r.in1    = in1;
        r.in2    = in2;
        return r;
    endfunction

    // Expected response and the matching update of the flag model
    function automatic alu_pkg::aluRespT predict(input alu_pkg::aluReqT r);
        alu_pkg::aluRespT    expected;
        alu_pkg::flagsT      upd;
        int                  a;
        int                  b;
        int                  s;
        int                  amt;
        int                  hi;
        logic                ovf;
        logic signed [W-1:0] sIn;
        a   = $signed(r.in1);
        b   = $signed(r.in2);
        amt = r.in2[3:0];
        hi  = (1 << (W - 1)) - 1;
        sIn = r.in1;
        ovf = 1'b0;
        upd = '0;
        case (r.opcode)
            alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_LW, alu_pkg::OP_SW: begin
                s = (r.opcode == alu_pkg::OP_SUB) ? a - b : a + b;
                expected.result = W'(clampInt(s, -hi - 1, hi));
                ovf = (s != clampInt(s, -hi - 1, hi));
                if (r.opcode inside {alu_pkg::OP_ADD, alu_pkg::OP_SUB}) begin
                    upd = '1;
                end
            end
            alu_pkg::OP_XOR: begin
                expected.result = r.in1 ^ r.in2;
                upd.zero = 1'b1;
            end
            alu_pkg::OP_RED: begin
                s = int'($signed(r.in1[15:8])) + int'($signed(r.in1[7:0]))
                  + int'($signed(r.in2[15:8])) + int'($signed(r.in2[7:0]));
                expected.result = W'(s);
            end
            alu_pkg::OP_SLL, alu_pkg::OP_SRA, alu_pkg::OP_ROR: begin
                if (r.opcode == alu_pkg::OP_SLL) begin
                    expected.result = r.in1 << amt;
                end else if (r.opcode == alu_pkg::OP_SRA) begin
                    expected.result = sIn >>> amt;
                end else begin
                    expected.result = (r.in1 >> amt) | (r.in1 << (W - amt));
                end
                upd.zero = 1'b1;
            end
            alu_pkg::OP_PADDSB: begin
                for (int i = 0; i < `NUM_LANES; i++) begin
                    s = int'($signed(r.in1[i*L +: L])) + int'($signed(r.in2[i*L +: L]));
                    expected.result[i*L +: L] = L'(clampInt(s, -8, 7));
                end
            end
            alu_pkg::OP_LLB: expected.result = {r.in1[15:8], r.in2[7:0]};
            alu_pkg::OP_LHB: expected.result = {r.in2[7:0], r.in1[7:0]};
            default:         expected.result = 16'hFFFF;
        endcase
        if (upd.zero) begin
            modelFlags.zero = (expected.result == '0);
        end
        if (upd.overflow) begin
            modelFlags.overflow = ovf;
        end
        if (upd.neg) begin
            modelFlags.neg = expected.result[W-1];
        end
        expected.flags = modelFlags;
        return expected;
    endfunction

    task automatic waitResponse();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!outValid && cycles < TIMEOUT);
        if (!outValid) begin
            abortRun("timeout: outValid did not rise within 20 cycles");
        end
    endtask

    task automatic runOp(input logic [3:0] code, input logic [W-1:0] in1,
                         input logic [W-1:0] in2, input string what);
        alu_pkg::aluReqT  r;
        alu_pkg::aluRespT expected;
        r        = makeReq(code, in1, in2);
        expected = predict(r);
        @(posedge clk);
        en  <= 1'b1;
        req <= r;
        @(posedge clk);
        en  <= 1'b0;
        waitResponse();
        compareResp(resp, expected, what);
    endtask

    task automatic testArith();
        repeat (20) begin
            runOp(alu_pkg::OP_ADD, randWord(), randWord(), "ADD random");
            runOp(alu_pkg::OP_SUB, randWord(), randWord(), "SUB random");
        end
        runOp(alu_pkg::OP_ADD, 16'h7FFF, 16'h0001, "ADD positive saturation");
        runOp(alu_pkg::OP_ADD, 16'h8000, 16'hFFFF, "ADD negative saturation");
        runOp(alu_pkg::OP_ADD, 16'h4000, 16'h4000, "ADD positive saturation");
        runOp(alu_pkg::OP_SUB, 16'h8000, 16'h0001, "SUB negative saturation");
        runOp(alu_pkg::OP_SUB, 16'h7FFF, 16'hFFFF, "SUB positive saturation");
        runOp(alu_pkg::OP_ADD, 16'hFFFF, 16'h0001, "ADD to zero");
        runOp(alu_pkg::OP_SUB, 16'h1234, 16'h1234, "SUB to zero");
    endtask

    task automatic testLogicShift();
        runOp(alu_pkg::OP_ADD, 16'h7FFF, 16'h7FFF, "ADD sets overflow"); // v=1 n=0
        repeat (5) begin
            runOp(alu_pkg::OP_XOR, randWord(), randWord(), "XOR random");
        end
        runOp(alu_pkg::OP_XOR, 16'hA5A5, 16'hA5A5, "XOR to zero");
        for (int amt = 0; amt < 16; amt++) begin
            runOp(alu_pkg::OP_SLL, randWord(), (randWord() & 16'hFFF0) | W'(amt), "SLL");
            runOp(alu_pkg::OP_SRA, randWord() | 16'h8000, W'(amt), "SRA negative");
            runOp(alu_pkg::OP_SRA, randWord() & 16'h7FFF, W'(amt), "SRA positive");
            runOp(alu_pkg::OP_ROR, randWord(), (randWord() & 16'hFFF0) | W'(amt), "ROR");
        end
        runOp(alu_pkg::OP_ADD, 16'h8000, 16'h8000, "ADD sets overflow and neg");
        runOp(alu_pkg::OP_SLL, 16'h0001, 16'h0000, "SLL keeps neg");
        runOp(alu_pkg::OP_SLL, 16'h8000, 16'h0001, "SLL to zero");
    endtask

    task automatic testRedPaddsb();
        runOp(alu_pkg::OP_SUB, 16'h0000, 16'h0001, "SUB sets neg");
        repeat (10) begin
            runOp(alu_pkg::OP_RED, randWord(), randWord(), "RED random");
            runOp(alu_pkg::OP_PADDSB, randWord(), randWord(), "PADDSB random");
        end
        runOp(alu_pkg::OP_RED, 16'h7F7F, 16'h7F7F, "RED largest");
        runOp(alu_pkg::OP_RED, 16'h8080, 16'h8080, "RED smallest");
        runOp(alu_pkg::OP_RED, 16'h0000, 16'h0000, "RED zero");
        runOp(alu_pkg::OP_PADDSB, 16'h7777, 16'h1111, "PADDSB positive clamp");
        runOp(alu_pkg::OP_PADDSB, 16'h8888, 16'h8888, "PADDSB negative clamp");
        runOp(alu_pkg::OP_PADDSB, 16'h7777, 16'h8888, "PADDSB mixed limits");
        runOp(alu_pkg::OP_PADDSB, 16'h7F81, 16'h18F8, "PADDSB per lane");
        runOp(alu_pkg::OP_PADDSB, 16'h1234, 16'hFEDC, "PADDSB to zero");
    endtask

    task automatic testByteAddr();
        runOp(alu_pkg::OP_SUB, 16'h1234, 16'h1234, "SUB sets zero"); // z=1 v=0 n=0
        repeat (5) begin
            runOp(alu_pkg::OP_LW, randWord(), randWord(), "LW address");
            runOp(alu_pkg::OP_SW, randWord(), randWord(), "SW address");
            runOp(alu_pkg::OP_LLB, randWord(), randWord(), "LLB");
            runOp(alu_pkg::OP_LHB, randWord(), randWord(), "LHB");
        end
        runOp(alu_pkg::OP_LW, 16'h7FFF, 16'h7FFF, "LW saturating");
        for (int code = 12; code < 16; code++) begin
            runOp(4'(code), randWord(), randWord(), "undefined opcode");
        end
    endtask

    task automatic testBackToBack();
        localparam int N = 16;
        alu_pkg::aluRespT expQ[$];
        alu_pkg::aluReqT  r;
        // Request driven in iteration j answers at the negedge of iteration j + 2
        for (int j = 0; j < N + 2; j++) begin
            @(posedge clk);
            if (j < N) begin
                r = makeReq(4'($urandom_range(15)), randWord(), randWord());
                expQ.push_back(predict(r));
                en  <= 1'b1;
                req <= r;
            end else begin
                en <= 1'b0;
            end
            @(negedge clk);
            if (j >= 2) begin
                if (!outValid) begin
                    abortRun("back-to-back response missing or late");
                end
                compareResp(resp, expQ.pop_front(), "back-to-back");
            end else if (outValid) begin
                abortRun("back-to-back response arrived too early");
            end
        end
        @(negedge clk);
        if (outValid) begin
            abortRun("extra outValid after back-to-back stream");
        end
    endtask

    initial begin
        void'($urandom(30));
        rst        = 1'b1;
        en         = 1'b0;
        req        = '0;
        modelFlags = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (outValid) begin
            abortRun("outValid high right after reset");
        end
        compareResp(resp, '0, "after reset");
        testArith();
        testLogicShift();
        testRedPaddsb();
        testByteAddr();
        testBackToBack();
        $display("test passed");
        $finish;
    end

endmodule

// File: all.f
+incdir+common
common/alu_pkg.sv
hw/aluInputStage.sv
hw/addSub.sv
hw/shifter.sv
hw/reduction.sv
paddsb/satNibbleAdder.sv
hw/aluControl.sv
hw/flagRegister.sv
hw/aluTop.sv
dv/alu_props.sv
dv/alu_tb.sv
